//--- files.f
src/wb_pkg.sv
src/wb_result_if.sv
src/mem_unit.sv
src/data_ram.sv
src/mul_unit.sv
src/div_unit.sv
src/wb_arbiter.sv
src/regfile.sv
src/wb_subsys_top.sv
sim/tb_wb_subsys.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --assert -Wno-fatal -j 0 \
    --top-module tb_wb_subsys \
    -f files.f \
    --Mdir "$build_dir" -o vsim_wb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$build_dir/vsim_wb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

if grep -q "^Regression passed$" "$log"; then
    exit 0
fi
exit 1

//--- sim/tb_wb_subsys.sv
module tb_wb_subsys;
    import wb_pkg::*;

    typedef struct packed {
        logic [xlen-1:0]       data;
        logic [reg_addr_w-1:0] rd;
        logic                  err;
        logic                  wen;
        logic                  chk;
        logic                  is_mem;
    } exp_t;

    localparam int ready_limit = 200;
    localparam int drain_limit = 2000;

    logic                  clk, rst_n;
    logic                  issue_valid, issue_ready;
    op_e                   issue_op;
    logic [reg_addr_w-1:0] issue_rd, commit_rd, rf_raddr;
    logic [xlen-1:0]       issue_a, issue_b, issue_pc;
    logic                  commit_valid, commit_wen, commit_error;
    logic [xlen-1:0]       commit_data, commit_pc, rf_rdata;

    exp_t                  sb [logic [xlen-1:0]];
    logic [xlen-1:0]       model_mem [logic [xlen-1:0]];
    logic [xlen-1:0]       addrs [$];
    integer                seed;
    int                    errors, tests, n_commits;
    bit                    timed_out;
    logic [xlen-1:0]       next_pc;

    // Commit outputs as seen mid-cycle, next to the model's expectation.
    logic                  s_valid, s_wen, s_err, s_mem_wen;
    logic [reg_addr_w-1:0] s_rd;
    logic [xlen-1:0]       s_pc, s_data;
    logic                  e_known;
    exp_t                  want;
    logic                  rf_check;
    logic [xlen-1:0]       rf_seen, rf_exp;

    wb_subsys_top dut_i (
        .clk(clk), .rst_n(rst_n), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rd(issue_rd), .issue_a(issue_a), .issue_b(issue_b), .issue_pc(issue_pc),
        .issue_ready(issue_ready), .commit_valid(commit_valid), .commit_wen(commit_wen),
        .commit_rd(commit_rd), .commit_data(commit_data), .commit_pc(commit_pc),
        .commit_error(commit_error), .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==================================================
    // Reference model
    // ==================================================

    function automatic logic [xlen-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic logic [reg_addr_w-1:0] rand_rd();
        logic [reg_addr_w-1:0] r;
        r = reg_addr_w'($random(seed));
        if (r == '0) r = reg_addr_w'(1);
        return r;
    endfunction

    function automatic logic [xlen-1:0] rand_addr();
        return xlen'(ram_addr_w'($random(seed))) << 3;
    endfunction

    function automatic exp_t predict(input op_e op, input logic [reg_addr_w-1:0] rd,
                                     input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        exp_t e;
        e.rd     = rd;
        e.err    = 1'b0;
        e.wen    = 1'b0;
        e.chk    = 1'b1;
        e.data   = '0;
        e.is_mem = (op == op_add) || (op == op_load) || (op == op_store);
        // Misaligned or out-of-range accesses fail. Stores never write a register.
        if (op == op_load || op == op_store)
            e.err = (a[2:0] != 3'd0) || (a[xlen-1:3] >= (xlen-3)'(ram_words));
        case (op)
            op_add:  e.data = a + b;
            op_load: begin
                e.chk = !e.err && model_mem.exists(a[xlen-1:3]);
                if (e.chk) e.data = model_mem[a[xlen-1:3]];
            end
            op_store: begin
                e.rd  = '0;
                e.chk = 1'b0;
            end
            op_mul:  e.data = a * b;
            op_divu: begin
                e.err  = (b == '0);
                e.data = e.err ? '1 : a / b;
            end
            op_remu: begin
                e.err  = (b == '0);
                e.data = e.err ? a : a % b;
            end
            default: e.chk = 1'b0;
        endcase
        // Only a register-writing operation that succeeds updates a real register.
        e.wen = (op != op_store) && (rd != '0) && !e.err;
        return e;
    endfunction

    always @(negedge clk) begin
        s_valid   = rst_n && commit_valid;
        s_mem_wen = rst_n && dut_i.mem_res_if.wen;
        s_pc      = commit_pc;
        s_data    = commit_data;
        s_rd      = commit_rd;
        s_wen     = commit_wen;
        s_err     = commit_error;
        e_known   = 1'b0;
        if (s_valid && sb.exists(s_pc)) begin
            e_known = 1'b1;
            want    = sb[s_pc];
            sb.delete(s_pc);
            n_commits++;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    a_known: assert property (@(posedge clk) disable iff (!rst_n) s_valid |-> e_known)
        else begin
            errors++;
            $display("Commit at pc %h matches no pending operation", s_pc);
        end
    a_data: assert property (@(posedge clk) disable iff (!rst_n)
                             s_valid && e_known && want.chk |-> s_data == want.data)
        else begin
            errors++;
            $display("CHECK FAILED commit_data got %h expected %h", s_data, want.data);
        end
    a_rd: assert property (@(posedge clk) disable iff (!rst_n)
                           s_valid && e_known |-> s_rd == want.rd)
        else begin
            errors++;
            $display("CHECK FAILED commit_rd got %h expected %h", s_rd, want.rd);
        end
    a_wen: assert property (@(posedge clk) disable iff (!rst_n)
                            s_valid && e_known |-> s_wen == want.wen)
        else begin
            errors++;
            $display("CHECK FAILED commit_wen got %h expected %h", s_wen, want.wen);
        end
    a_err: assert property (@(posedge clk) disable iff (!rst_n)
                            s_valid && e_known |-> s_err == want.err)
        else begin
            errors++;
            $display("CHECK FAILED commit_error got %h expected %h", s_err, want.err);
        end
    // Memory has top priority, so its result must never wait behind another unit.
    a_mem_first: assert property (@(posedge clk) disable iff (!rst_n)
                                  s_mem_wen |=> s_valid && e_known && want.is_mem)
        else begin
            errors++;
            $display("A memory result did not commit in the cycle after it was registered");
        end
    a_rf: assert property (@(posedge clk) disable iff (!rst_n) rf_check |-> rf_seen == rf_exp)
        else begin
            errors++;
            $display("CHECK FAILED rf_rdata got %h expected %h", rf_seen, rf_exp);
        end

    // ==================================================
    // Stimulus
    // ==================================================

    task automatic issue(input op_e op, input logic [reg_addr_w-1:0] rd,
                         input logic [xlen-1:0] a, input logic [xlen-1:0] b);
        exp_t e;
        int   waited;
        if (timed_out) return;
        e           = predict(op, rd, a, b);
        issue_valid = 1'b1;
        issue_op    = op;
        issue_rd    = rd;
        issue_a     = a;
        issue_b     = b;
        issue_pc    = next_pc;
        waited      = 0;
        #1;
        while (!issue_ready && !timed_out) begin
            if (waited == ready_limit) begin
                $display("Timeout: the DUT never accepted %s at pc %h", op.name(), next_pc);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                #1;
                waited++;
            end
        end
        if (!timed_out) begin
            sb[next_pc] = e;
            if (op == op_store && !e.err) model_mem[a[xlen-1:3]] = b;
            next_pc = next_pc + xlen'(4);
            @(negedge clk);
        end
        issue_valid = 1'b0;
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (sb.num() != 0 && !timed_out) begin
            if (waited == drain_limit) begin
                $display("Timeout: %0d %s results never committed", sb.num(), what);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                waited++;
            end
        end
        repeat (2) @(negedge clk);
    endtask

    task automatic check_reg(input logic [reg_addr_w-1:0] r, input logic [xlen-1:0] v);
        rf_raddr = r;
        rf_exp   = v;
        #1;
        rf_seen  = rf_rdata;
        rf_check = 1'b1;
        @(negedge clk);
        rf_check = 1'b0;
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before && !timed_out) $display("test %-12s ok", name);
        else $display("test %-12s FAILED", name);
    endtask

    initial begin
        int                    e0;
        logic [xlen-1:0]       a, b;
        logic [reg_addr_w-1:0] r;
        seed        = 32'h0ef9_1327;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = op_add;
        issue_rd    = '0;
        issue_a     = '0;
        issue_b     = '0;
        issue_pc    = '0;
        rf_raddr    = '0;
        rf_check    = 1'b0;
        errors      = 0;
        tests       = 0;
        n_commits   = 0;
        timed_out   = 1'b0;
        next_pc     = 64'h1000;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (!commit_valid && issue_ready)
            else begin
                errors++;
                $display("DUT is not idle and ready after reset");
            end

        e0 = errors;
        for (int i = 0; i < 8; i++) begin
            a = rand64();
            b = rand64();
            r = rand_rd();
            issue(op_add, r, a, b);
            drain("add");
            check_reg(r, a + b);
        end
        issue(op_add, '0, rand64(), rand64());
        drain("add");
        check_reg('0, '0);
        end_test("add", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) begin
            a = rand_addr();
            addrs.push_back(a);
            issue(op_store, rand_rd(), a, rand64());
        end
        drain("store");
        foreach (addrs[i]) issue(op_load, rand_rd(), addrs[i], '0);
        drain("load");
        end_test("store_load", e0);

        e0 = errors;
        for (int i = 0; i < 6; i++) issue(op_mul, rand_rd(), rand64(), rand64());
        drain("multiply");
        for (int i = 0; i < 4; i++) begin
            a = rand64();
            b = (i % 2 == 0) ? rand64() : xlen'($unsigned($random(seed)));
            issue(op_divu, rand_rd(), a, b);
            issue(op_remu, rand_rd(), a, b);
        end
        drain("divide");
        end_test("mul_div", e0);

        e0 = errors;
        a = rand64();
        issue(op_divu, rand_rd(), a, '0);
        issue(op_remu, rand_rd(), a, '0);
        drain("divide by zero");
        end_test("div_zero", e0);

        e0 = errors;
        issue(op_load, rand_rd(), rand_addr() + xlen'(8 * ram_words), '0);
        issue(op_load, rand_rd(), rand_addr() | xlen'(5), '0);
        drain("bus error");
        end_test("bus_error", e0);

        // An add reaches the arbiter together with the first of the two multiplies
        // before it, and the stream lasts longer than the divide.
        e0 = errors;
        issue(op_divu, rand_rd(), rand64(), xlen'($unsigned($random(seed))));
        for (int i = 0; i < 16; i++) begin
            issue(op_mul, rand_rd(), rand64(), rand64());
            issue(op_mul, rand_rd(), rand64(), rand64());
            issue(op_add, rand_rd(), rand64(), rand64());
            issue(op_load, rand_rd(), addrs[i % addrs.size()], '0);
        end
        drain("contention");
        end_test("contention", e0);

        $display("tests %0d, commits %0d, failed checks %0d", tests, n_commits, errors);
        if (errors == 0 && !timed_out) $display("Regression passed");
        else $display("Regression failed");
        $finish;
    end

endmodule

//--- src/data_ram.sv
module data_ram (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cyc,
    input  logic                    stb,
    input  logic                    we,
    input  logic [wb_pkg::xlen-1:0] adr,
    input  logic [wb_pkg::xlen-1:0] dat_w,
    output logic [wb_pkg::xlen-1:0] dat_r,
    output logic                    ack,
    output logic                    err
);
    import wb_pkg::*;

    logic [xlen-1:0]       mem [ram_words];
    logic [ram_addr_w-1:0] word;
    logic                  in_range;
    logic                  req;

    assign word     = adr[3 +: ram_addr_w];
    assign in_range = (adr[xlen-1:3] < ram_words);

    // The strobe stays high during the answer cycle, so it is not taken twice.
    assign req = cyc && stb && !ack && !err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= req && in_range;
            err <= req && !in_range;
        end
    end

    always_ff @(posedge clk) begin
        if (req && in_range) begin
            if (we) mem[word] <= dat_w;
            dat_r <= mem[word];
        end
    end

endmodule

//--- src/div_unit.sv
module div_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  wb_pkg::op_e                   op,
    input  logic [wb_pkg::reg_addr_w-1:0] rd,
    input  logic [wb_pkg::xlen-1:0]       a,
    input  logic [wb_pkg::xlen-1:0]       b,
    input  logic [wb_pkg::xlen-1:0]       pc,
    output logic                          ready,
    wb_result_if.producer                 res
);
    import wb_pkg::*;

    typedef enum logic [1:0] {idle, run, done} state_e;

    state_e                state;
    logic [div_cnt_w-1:0]  cnt;
    logic [xlen-1:0]       quo;
    logic [xlen-1:0]       rem;
    logic [xlen-1:0]       dvsr;
    logic [xlen-1:0]       pc_q;
    logic [reg_addr_w-1:0] rd_q;
    logic                  want_rem;
    logic                  err_q;
    logic [xlen:0]         shifted;
    logic [xlen:0]         diff;

    assign ready = (state == idle);

    // ==================================================
    // Control
    // ==================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
            cnt   <= '0;
        end else begin
            case (state)
                idle: begin
                    cnt <= '0;
                    if (start) state <= (b == '0) ? done : run;
                end
                run: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == div_cnt_w'(xlen - 1)) state <= done;
                end
                default: begin
                    if (!res.block) state <= idle;
                end
            endcase
        end
    end

    // ==================================================
    // Restoring shift-subtract datapath
    // ==================================================

    // The next dividend bit enters the partial remainder each cycle.
    assign shifted = {rem, quo[xlen-1]};
    assign diff    = shifted - {1'b0, dvsr};

    always_ff @(posedge clk) begin
        if (start) begin
            // A zero divisor gives all ones and keeps the dividend as remainder.
            quo      <= (b == '0) ? '1 : a;
            rem      <= (b == '0) ? a : '0;
            dvsr     <= b;
            rd_q     <= rd;
            pc_q     <= pc;
            want_rem <= (op == op_remu);
            err_q    <= (b == '0);
        end else if (state == run) begin
            if (!diff[xlen]) begin
                rem <= diff[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b1};
            end else begin
                rem <= shifted[xlen-1:0];
                quo <= {quo[xlen-2:0], 1'b0};
            end
        end
    end

    assign res.wen   = (state == done);
    assign res.rd    = rd_q;
    assign res.data  = want_rem ? rem : quo;
    assign res.pc    = pc_q;
    assign res.error = err_q;

endmodule

//--- src/mem_unit.sv
module mem_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  wb_pkg::op_e                   op,
    input  logic [wb_pkg::reg_addr_w-1:0] rd,
    input  logic [wb_pkg::xlen-1:0]       a,
    input  logic [wb_pkg::xlen-1:0]       b,
    input  logic [wb_pkg::xlen-1:0]       pc,
    output logic                          ready,
    wb_result_if.producer                 res,
    output logic                          cyc,
    output logic                          stb,
    output logic                          we,
    output logic [wb_pkg::xlen-1:0]       adr,
    output logic [wb_pkg::xlen-1:0]       dat_w,
    input  logic [wb_pkg::xlen-1:0]       dat_r,
    input  logic                          ack,
    input  logic                          err
);
    import wb_pkg::*;

    typedef enum logic [1:0] {idle, bus, result} state_e;

    state_e                state;
    logic                  is_store_q;
    logic                  err_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       data_q;
    logic [xlen-1:0]       pc_q;
    logic [xlen-1:0]       adr_q;
    logic [xlen-1:0]       wdat_q;

    // A result that leaves at this edge frees the unit for a new operation.
    assign ready = (state == idle) || (state == result && !res.block);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else if (start) begin
            // Adds and misaligned accesses never touch the bus.
            if (op == op_add || a[2:0] != 3'b000) state <= result;
            else state <= bus;
        end else if (state == bus && (ack || err)) begin
            state <= result;
        end else if (state == result && !res.block) begin
            state <= idle;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            is_store_q <= (op == op_store);
            rd_q       <= (op == op_store) ? '0 : rd;
            data_q     <= (op == op_add) ? a + b : b;
            err_q      <= (op != op_add) && (a[2:0] != 3'b000);
            pc_q       <= pc;
            adr_q      <= a;
            wdat_q     <= b;
        end else if (state == bus && (ack || err)) begin
            if (!is_store_q) data_q <= dat_r;
            err_q <= err;
        end
    end

    assign cyc   = (state == bus);
    assign stb   = (state == bus);
    assign we    = is_store_q;
    assign adr   = adr_q;
    assign dat_w = wdat_q;

    assign res.wen   = (state == result);
    assign res.rd    = rd_q;
    assign res.data  = data_q;
    assign res.pc    = pc_q;
    assign res.error = err_q;

endmodule

//--- src/mul_unit.sv
module mul_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [wb_pkg::reg_addr_w-1:0] rd,
    input  logic [wb_pkg::xlen-1:0]       a,
    input  logic [wb_pkg::xlen-1:0]       b,
    input  logic [wb_pkg::xlen-1:0]       pc,
    output logic                          ready,
    wb_result_if.producer                 res
);
    import wb_pkg::*;

    logic                  advance;
    logic [mul_stages-1:0] vld;
    logic [reg_addr_w-1:0] rd_pipe [mul_stages];
    logic [xlen-1:0]       pc_pipe [mul_stages];
    logic [xlen-1:0]       part_lo;
    logic [xlen/2-1:0]     part_hi;
    logic [xlen-1:0]       prod_mid;
    logic [xlen-1:0]       prod_out;

    // A blocked result freezes every stage behind it.
    assign advance = !res.block;
    assign ready   = advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) vld <= '0;
        else if (advance) vld <= {vld[mul_stages-2:0], start};
    end

    // Only the low half of the upper partial product reaches the low 64 bits.
    always_ff @(posedge clk) begin
        if (advance) begin
            rd_pipe[0] <= rd;
            pc_pipe[0] <= pc;
            for (int i = 1; i < mul_stages; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
                pc_pipe[i] <= pc_pipe[i-1];
            end
            part_lo  <= a * b[xlen/2-1:0];
            part_hi  <= a[xlen/2-1:0] * b[xlen-1:xlen/2];
            prod_mid <= part_lo + {part_hi, {(xlen/2){1'b0}}};
            prod_out <= prod_mid;
        end
    end

    assign res.wen   = vld[mul_stages-1];
    assign res.rd    = rd_pipe[mul_stages-1];
    assign res.data  = prod_out;
    assign res.pc    = pc_pipe[mul_stages-1];
    assign res.error = 1'b0;

endmodule

//--- src/regfile.sv
module regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic [wb_pkg::reg_addr_w-1:0] waddr,
    input  logic [wb_pkg::xlen-1:0]       wdata,
    input  logic [wb_pkg::reg_addr_w-1:0] raddr,
    output logic [wb_pkg::xlen-1:0]       rdata
);
    import wb_pkg::*;

    // Register x0 has no storage.
    logic [xlen-1:0] regs [1:(1 << reg_addr_w) - 1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < (1 << reg_addr_w); i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        if (raddr == '0) rdata = '0;
        else rdata = regs[raddr];
    end

endmodule

//--- src/wb_arbiter.sv
module wb_arbiter (
    input  logic                          clk,
    input  logic                          rst_n,
    wb_result_if.arbiter                  mem_res,
    wb_result_if.arbiter                  div_res,
    wb_result_if.arbiter                  mul_res,
    output logic                          commit_valid,
    output logic                          commit_wen,
    output logic [wb_pkg::reg_addr_w-1:0] commit_rd,
    output logic [wb_pkg::xlen-1:0]       commit_data,
    output logic [wb_pkg::xlen-1:0]       commit_pc,
    output logic                          commit_error
);
    import wb_pkg::*;

    logic [n_units-1:0]    in_wen;
    logic [n_units-1:0]    in_err;
    logic [reg_addr_w-1:0] in_rd [n_units];
    logic [xlen-1:0]       in_data [n_units];
    logic [xlen-1:0]       in_pc [n_units];
    logic [n_units-1:0]    vld_q;
    logic [n_units-1:0]    err_q;
    logic [reg_addr_w-1:0] rd_q [n_units];
    logic [xlen-1:0]       data_q [n_units];
    logic [xlen-1:0]       pc_q [n_units];
    logic [n_units-1:0]    blk;
    unit_e                 win;

    always_comb begin
        in_wen[unit_mem]  = mem_res.wen;
        in_err[unit_mem]  = mem_res.error;
        in_rd[unit_mem]   = mem_res.rd;
        in_data[unit_mem] = mem_res.data;
        in_pc[unit_mem]   = mem_res.pc;
        in_wen[unit_div]  = div_res.wen;
        in_err[unit_div]  = div_res.error;
        in_rd[unit_div]   = div_res.rd;
        in_data[unit_div] = div_res.data;
        in_pc[unit_div]   = div_res.pc;
        in_wen[unit_mul]  = mul_res.wen;
        in_err[unit_mul]  = mul_res.error;
        in_rd[unit_mul]   = mul_res.rd;
        in_data[unit_mul] = mul_res.data;
        in_pc[unit_mul]   = mul_res.pc;
    end

    // A held entry keeps its register until it wins.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) vld_q <= '0;
        else begin
            for (int i = 0; i < n_units; i++) begin
                if (!blk[i]) vld_q[i] <= in_wen[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < n_units; i++) begin
            if (!blk[i]) begin
                err_q[i]  <= in_err[i];
                rd_q[i]   <= in_rd[i];
                data_q[i] <= in_data[i];
                pc_q[i]   <= in_pc[i];
            end
        end
    end

    // The lowest unit_e value among the registered entries wins.
    always_comb begin
        win = unit_mul;
        for (int i = n_units - 1; i >= 0; i--) begin
            if (vld_q[i]) win = unit_e'(i);
        end
        for (int i = 0; i < n_units; i++) begin
            blk[i] = vld_q[i] && (unit_e'(i) != win);
        end
    end

    assign mem_res.block = blk[unit_mem];
    assign div_res.block = blk[unit_div];
    assign mul_res.block = blk[unit_mul];

    assign commit_valid = |vld_q;
    assign commit_rd    = rd_q[win];
    assign commit_data  = data_q[win];
    assign commit_pc    = pc_q[win];
    assign commit_error = err_q[win];
    // Stores carry rd zero, and failed operations leave the register file alone.
    assign commit_wen   = commit_valid && (commit_rd != '0) && !commit_error;

endmodule

//--- src/wb_pkg.sv
package wb_pkg;

    // ==================================================
    // Widths and sizes
    // ==================================================

    localparam int xlen = 64;
    localparam int reg_addr_w = 5;

    // Data RAM depth in 64-bit words.
    localparam int ram_words = 256;
    localparam int ram_addr_w = $clog2(ram_words);

    localparam int mul_stages = 3;

    // One count per quotient bit.
    localparam int div_cnt_w = $clog2(xlen);

    localparam int n_units = 3;

    // ==================================================
    // Encodings
    // ==================================================

    typedef enum logic [2:0] {
        op_add,
        op_load,
        op_store,
        op_mul,
        op_divu,
        op_remu
    } op_e;

    // Result sources, listed from highest to lowest writeback priority.
    typedef enum logic [1:0] {
        unit_mem,
        unit_div,
        unit_mul
    } unit_e;

endpackage

//--- src/wb_result_if.sv
interface wb_result_if;
    import wb_pkg::*;

    logic                  wen;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       data;
    logic [xlen-1:0]       pc;
    logic                  error;
    logic                  block;

    // The producer keeps its outputs steady for as long as block is high.
    modport producer (
        output wen, rd, data, pc, error,
        input  block
    );

    modport arbiter (
        input  wen, rd, data, pc, error,
        output block
    );

endinterface

//--- src/wb_subsys_top.sv
module wb_subsys_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          issue_valid,
    input  wb_pkg::op_e                   issue_op,
    input  logic [wb_pkg::reg_addr_w-1:0] issue_rd,
    input  logic [wb_pkg::xlen-1:0]       issue_a,
    input  logic [wb_pkg::xlen-1:0]       issue_b,
    input  logic [wb_pkg::xlen-1:0]       issue_pc,
    output logic                          issue_ready,
    output logic                          commit_valid,
    output logic                          commit_wen,
    output logic [wb_pkg::reg_addr_w-1:0] commit_rd,
    output logic [wb_pkg::xlen-1:0]       commit_data,
    output logic [wb_pkg::xlen-1:0]       commit_pc,
    output logic                          commit_error,
    input  logic [wb_pkg::reg_addr_w-1:0] rf_raddr,
    output logic [wb_pkg::xlen-1:0]       rf_rdata
);
    import wb_pkg::*;

    logic            sel_mem, sel_mul, sel_div;
    logic            mem_ready, mul_ready, div_ready;
    logic            wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
    logic [xlen-1:0] wb_adr, wb_dat_w, wb_dat_r;

    wb_result_if mem_res_if ();
    wb_result_if div_res_if ();
    wb_result_if mul_res_if ();

    // ==================================================
    // Issue routing
    // ==================================================

    always_comb begin
        sel_mem = 1'b0;
        sel_mul = 1'b0;
        sel_div = 1'b0;
        case (issue_op)
            op_mul:           sel_mul = 1'b1;
            op_divu, op_remu: sel_div = 1'b1;
            default:          sel_mem = 1'b1;
        endcase
    end

    assign issue_ready = (sel_mem && mem_ready) || (sel_mul && mul_ready) ||
                         (sel_div && div_ready);

    mem_unit mem_unit_i (
        .clk(clk), .rst_n(rst_n), .start(issue_valid && sel_mem && mem_ready),
        .op(issue_op), .rd(issue_rd), .a(issue_a), .b(issue_b), .pc(issue_pc),
        .ready(mem_ready), .res(mem_res_if.producer),
        .cyc(wb_cyc), .stb(wb_stb), .we(wb_we), .adr(wb_adr), .dat_w(wb_dat_w),
        .dat_r(wb_dat_r), .ack(wb_ack), .err(wb_err)
    );

    data_ram data_ram_i (
        .clk(clk), .rst_n(rst_n), .cyc(wb_cyc), .stb(wb_stb), .we(wb_we),
        .adr(wb_adr), .dat_w(wb_dat_w), .dat_r(wb_dat_r), .ack(wb_ack), .err(wb_err)
    );

    mul_unit mul_unit_i (
        .clk(clk), .rst_n(rst_n), .start(issue_valid && sel_mul && mul_ready),
        .rd(issue_rd), .a(issue_a), .b(issue_b), .pc(issue_pc),
        .ready(mul_ready), .res(mul_res_if.producer)
    );

    div_unit div_unit_i (
        .clk(clk), .rst_n(rst_n), .start(issue_valid && sel_div && div_ready),
        .op(issue_op), .rd(issue_rd), .a(issue_a), .b(issue_b), .pc(issue_pc),
        .ready(div_ready), .res(div_res_if.producer)
    );

    // ==================================================
    // Writeback
    // ==================================================

    wb_arbiter wb_arbiter_i (
        .clk(clk), .rst_n(rst_n), .mem_res(mem_res_if.arbiter),
        .div_res(div_res_if.arbiter), .mul_res(mul_res_if.arbiter),
        .commit_valid(commit_valid), .commit_wen(commit_wen), .commit_rd(commit_rd),
        .commit_data(commit_data), .commit_pc(commit_pc), .commit_error(commit_error)
    );

    regfile regfile_i (
        .clk(clk), .rst_n(rst_n), .we(commit_wen), .waddr(commit_rd),
        .wdata(commit_data), .raddr(rf_raddr), .rdata(rf_rdata)
    );

endmodule
